// File: hdl/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// First instruction fetched out of reset.
`define FETCH_RESET_PC 32'hAAAAA000

// 64-bit memory beats per 256-bit cache line.
`define LINE_BEATS 4

// Direct-mapped sets in the instruction cache.
`define CACHE_SETS 16

// Entries in the instruction queue.
`define QUEUE_DEPTH 32

`endif

// File: hdl/fetch_pkg.sv
`include "fetch_consts.svh"

package fetch_pkg;

    typedef logic [31:0] addr_t;                  // Byte address.
    typedef logic [31:0] word_t;                  // One instruction.
    typedef logic [63:0] beat_t;                  // One memory beat.
    typedef logic [`LINE_BEATS*64-1:0] line_t;    // One cache line.

    // A finished burst with its line-aligned address.
    typedef struct packed {
        addr_t addr;
        line_t data;
    } line_fill_t;

    typedef struct packed {
        addr_t pc;
        word_t word;
    } instr_t;

    typedef enum logic [1:0] {
        CS_IDLE,
        CS_LOOKUP,
        CS_REQ,
        CS_WAIT
    } cache_state_e;

endpackage : fetch_pkg

// File: hdl/deserializer.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module deserializer (
    input  logic                    clk,
    input  logic                    reset_i,
    input  fetch_pkg::addr_t        bmem_raddr_i,
    input  fetch_pkg::beat_t        bmem_rdata_i,
    input  logic                    bmem_rvalid_i,
    output fetch_pkg::line_fill_t   fill_o,
    output logic                    fill_valid_o
);

    localparam int BEAT_BITS   = $bits(fetch_pkg::beat_t);
    localparam int LINE_BITS   = $bits(fetch_pkg::line_t);
    localparam int ADDR_BITS   = $bits(fetch_pkg::addr_t);
    localparam int OFFSET_BITS = $clog2(LINE_BITS / 8);
    localparam int COUNT_BITS  = $clog2(`LINE_BEATS);

    logic [COUNT_BITS-1:0] beat_cnt_q;
    logic                  last_beat;
    fetch_pkg::line_t      line_q;
    fetch_pkg::addr_t      base_q;

    assign last_beat = bmem_rvalid_i && (beat_cnt_q == COUNT_BITS'(`LINE_BEATS - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            beat_cnt_q   <= '0;
            fill_valid_o <= 1'b0;
        end else begin
            fill_valid_o <= last_beat;          // Line complete one cycle later.
            if (bmem_rvalid_i) begin
                beat_cnt_q <= last_beat ? '0 : beat_cnt_q + 1'b1;
            end
        end
    end

    // Beats shift in from the top so the first one ends up lowest.
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[LINE_BITS-1:BEAT_BITS]};
            if (beat_cnt_q == '0) begin
                base_q <= {bmem_raddr_i[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            end
        end
    end

    assign fill_o.addr = base_q;
    assign fill_o.data = line_q;

    // A burst never strays outside the line its first beat named.
    a_same_line: assert property (@(posedge clk) disable iff (reset_i)
        (bmem_rvalid_i && beat_cnt_q != '0)
            |-> bmem_raddr_i[ADDR_BITS-1:OFFSET_BITS] == base_q[ADDR_BITS-1:OFFSET_BITS]);

endmodule : deserializer

// File: hdl/cache.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module cache (
    input  logic                    clk,
    input  logic                    reset_i,

    input  logic                    req_i,
    input  fetch_pkg::addr_t        req_addr_i,
    output logic                    resp_o,
    output fetch_pkg::line_t        line_o,

    input  fetch_pkg::line_fill_t   fill_i,
    input  logic                    fill_valid_i,

    output fetch_pkg::addr_t        bmem_addr_o,
    output logic                    bmem_read_o,
    input  logic                    bmem_ready_i
);

    localparam int ADDR_BITS   = $bits(fetch_pkg::addr_t);
    localparam int OFFSET_BITS = $clog2($bits(fetch_pkg::line_t) / 8);
    localparam int INDEX_BITS  = $clog2(`CACHE_SETS);
    localparam int TAG_BITS    = ADDR_BITS - OFFSET_BITS - INDEX_BITS;

    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;

    fetch_pkg::cache_state_e state_q;
    fetch_pkg::addr_t        addr_q;

    fetch_pkg::line_t        data_arr [`CACHE_SETS];
    tag_t                    tag_arr  [`CACHE_SETS];
    logic [`CACHE_SETS-1:0]  valid_q;

    index_t look_idx;
    tag_t   look_tag;
    index_t fill_idx;
    tag_t   fill_tag;
    logic   hit;

    assign look_idx = addr_q[OFFSET_BITS +: INDEX_BITS];
    assign look_tag = addr_q[ADDR_BITS-1 -: TAG_BITS];
    assign fill_idx = fill_i.addr[OFFSET_BITS +: INDEX_BITS];
    assign fill_tag = fill_i.addr[ADDR_BITS-1 -: TAG_BITS];
    assign hit      = valid_q[look_idx] && (tag_arr[look_idx] == look_tag);

    assign bmem_read_o = (state_q == fetch_pkg::CS_REQ);
    assign bmem_addr_o = {addr_q[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= fetch_pkg::CS_IDLE;
            valid_q <= '0;
            resp_o  <= 1'b0;
        end else begin
            resp_o <= 1'b0;
            case (state_q)
                fetch_pkg::CS_IDLE: begin
                    if (req_i) begin
                        state_q <= fetch_pkg::CS_LOOKUP;
                    end
                end
                fetch_pkg::CS_LOOKUP: begin
                    resp_o  <= hit;
                    state_q <= hit ? fetch_pkg::CS_IDLE : fetch_pkg::CS_REQ;
                end
                fetch_pkg::CS_REQ: begin
                    if (bmem_ready_i) begin         // Memory took the request.
                        state_q <= fetch_pkg::CS_WAIT;
                    end
                end
                fetch_pkg::CS_WAIT: begin
                    if (fill_valid_i) begin
                        valid_q[fill_idx] <= 1'b1;
                        resp_o            <= 1'b1;
                        state_q           <= fetch_pkg::CS_IDLE;
                    end
                end
                default: state_q <= fetch_pkg::CS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == fetch_pkg::CS_IDLE && req_i) begin
            addr_q <= req_addr_i;
        end
        if (state_q == fetch_pkg::CS_LOOKUP) begin
            line_o <= data_arr[look_idx];
        end
        if (state_q == fetch_pkg::CS_WAIT && fill_valid_i) begin
            data_arr[fill_idx] <= fill_i.data;
            tag_arr[fill_idx]  <= fill_tag;
            line_o             <= fill_i.data;  // Answer straight from the fill.
        end
    end

    a_bmem_aligned: assert property (@(posedge clk) disable iff (reset_i)
        bmem_read_o |-> bmem_addr_o[OFFSET_BITS-1:0] == '0);

    // Fetch keeps at most one request in flight.
    a_req_idle: assert property (@(posedge clk) disable iff (reset_i)
        req_i |-> state_q == fetch_pkg::CS_IDLE);

endmodule : cache

// File: hdl/queue.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module queue (
    input  logic                clk,
    input  logic                reset_i,
    input  fetch_pkg::instr_t   data_i,
    input  logic                enq_i,
    output logic                full_o,
    output fetch_pkg::instr_t   data_o,
    input  logic                deq_i,
    output logic                empty_o,
    input  logic                flush_i
);

    localparam int DEPTH    = `QUEUE_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    fetch_pkg::instr_t   mem [DEPTH];
    logic [PTR_BITS-1:0] rptr_q;
    logic [PTR_BITS-1:0] wptr_q;
    logic [CNT_BITS-1:0] count_q;

    logic [PTR_BITS-1:0] rptr_base;
    logic [PTR_BITS-1:0] wptr_base;
    logic [CNT_BITS-1:0] count_base;
    logic                do_enq;
    logic                do_deq;

    // Flush first, then this cycle's push and pop.
    always_comb begin
        rptr_base  = flush_i ? '0 : rptr_q;
        wptr_base  = flush_i ? '0 : wptr_q;
        count_base = flush_i ? '0 : count_q;
        do_enq     = enq_i && (count_base != CNT_BITS'(DEPTH));
        do_deq     = deq_i && (count_base != '0);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rptr_q  <= '0;
            wptr_q  <= '0;
            count_q <= '0;
        end else begin
            rptr_q  <= rptr_base + PTR_BITS'(do_deq);   // Wraps at the power-of-two depth.
            wptr_q  <= wptr_base + PTR_BITS'(do_enq);
            count_q <= count_base + CNT_BITS'(do_enq) - CNT_BITS'(do_deq);
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wptr_base] <= data_i;
        end
    end

    assign data_o  = mem[rptr_q];
    assign full_o  = (count_q == CNT_BITS'(DEPTH));
    assign empty_o = (count_q == '0);

    // The producer must honour full.
    a_no_enq_full: assert property (@(posedge clk) disable iff (reset_i)
        enq_i |-> !full_o);

endmodule : queue

// File: hdl/fetch.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch (
    input  logic                clk,
    input  logic                reset_i,

    input  logic                redirect_i,
    input  fetch_pkg::addr_t    redirect_pc_i,

    output logic                req_o,
    output fetch_pkg::addr_t    req_addr_o,
    input  logic                resp_i,
    input  fetch_pkg::line_t    line_i,

    output logic                enq_o,
    output fetch_pkg::instr_t   data_o,
    input  logic                full_i
);

    localparam int ADDR_BITS   = $bits(fetch_pkg::addr_t);
    localparam int WORD_BITS   = $bits(fetch_pkg::word_t);
    localparam int LINE_BITS   = $bits(fetch_pkg::line_t);
    localparam int OFFSET_BITS = $clog2(LINE_BITS / 8);
    localparam int SEL_BITS    = $clog2(LINE_BITS / WORD_BITS);
    localparam int TAG_BITS    = ADDR_BITS - OFFSET_BITS;

    fetch_pkg::addr_t    pc_q;
    fetch_pkg::line_t    buf_line_q;
    logic [TAG_BITS-1:0] buf_tag_q;
    logic                buf_valid_q;
    logic                pending_q;
    logic                discard_q;     // Outstanding response belongs to an old pc.

    logic                buf_hit;
    logic [SEL_BITS-1:0] word_sel;

    assign buf_hit  = buf_valid_q && (buf_tag_q == pc_q[ADDR_BITS-1:OFFSET_BITS]);
    assign word_sel = pc_q[2 +: SEL_BITS];

    assign enq_o       = buf_hit && !full_i && !redirect_i;
    assign req_o       = !buf_hit && !pending_q && !redirect_i;
    assign req_addr_o  = pc_q;
    assign data_o.pc   = pc_q;
    assign data_o.word = buf_line_q[word_sel * WORD_BITS +: WORD_BITS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q        <= `FETCH_RESET_PC;
            buf_valid_q <= 1'b0;
            pending_q   <= 1'b0;
            discard_q   <= 1'b0;
        end else if (redirect_i) begin
            pc_q        <= redirect_pc_i;
            buf_valid_q <= 1'b0;
            discard_q   <= pending_q && !resp_i;
            if (resp_i) begin
                pending_q <= 1'b0;          // Late response is dropped.
            end
        end else begin
            if (req_o) begin
                pending_q <= 1'b1;
            end
            if (resp_i) begin
                pending_q <= 1'b0;
                discard_q <= 1'b0;
                if (!discard_q) begin
                    buf_valid_q <= 1'b1;
                end
            end
            if (enq_o) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    // Pc is frozen while a request is pending, so it names the returned line.
    always_ff @(posedge clk) begin
        if (resp_i && !discard_q && !redirect_i) begin
            buf_line_q <= line_i;
            buf_tag_q  <= pc_q[ADDR_BITS-1:OFFSET_BITS];
        end
    end

endmodule : fetch

// File: hdl/cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic                clk,
    input  logic                reset_i,

    output fetch_pkg::addr_t    bmem_addr_o,
    output logic                bmem_read_o,
    input  logic                bmem_ready_i,

    input  fetch_pkg::addr_t    bmem_raddr_i,
    input  fetch_pkg::beat_t    bmem_rdata_i,
    input  logic                bmem_rvalid_i,

    input  logic                redirect_i,
    input  fetch_pkg::addr_t    redirect_pc_i,

    output fetch_pkg::instr_t   instr_o,
    output logic                instr_valid_o,
    input  logic                instr_deq_i
);

    fetch_pkg::line_fill_t  fill;
    logic                   fill_valid;
    logic                   req;
    fetch_pkg::addr_t       req_addr;
    logic                   resp;
    fetch_pkg::line_t       line;
    logic                   enq;
    fetch_pkg::instr_t      enq_data;
    logic                   queue_full;
    logic                   queue_empty;

    deserializer cache_line_adapter (
        .clk          (clk),
        .reset_i      (reset_i),
        .bmem_raddr_i (bmem_raddr_i),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_rvalid_i(bmem_rvalid_i),
        .fill_o       (fill),
        .fill_valid_o (fill_valid)
    );

    cache instruction_cache (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_i       (req),
        .req_addr_i  (req_addr),
        .resp_o      (resp),
        .line_o      (line),
        .fill_i      (fill),
        .fill_valid_i(fill_valid),
        .bmem_addr_o (bmem_addr_o),
        .bmem_read_o (bmem_read_o),
        .bmem_ready_i(bmem_ready_i)
    );

    fetch fetch_unit (
        .clk          (clk),
        .reset_i      (reset_i),
        .redirect_i   (redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .req_o        (req),
        .req_addr_o   (req_addr),
        .resp_i       (resp),
        .line_i       (line),
        .enq_o        (enq),
        .data_o       (enq_data),
        .full_i       (queue_full)
    );

    queue instruction_queue (
        .clk    (clk),
        .reset_i(reset_i),
        .data_i (enq_data),
        .enq_i  (enq),
        .full_o (queue_full),
        .data_o (instr_o),
        .deq_i  (instr_deq_i),
        .empty_o(queue_empty),
        .flush_i(redirect_i)        // Redirect drops everything queued.
    );

    assign instr_valid_o = !queue_empty;

endmodule : cpu

// File: tb/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam logic [31:0] RESET_PC = 32'hAAAAA000;
    localparam logic [31:0] MAGIC    = 32'h5A5A5A5A;   // Memory word is its address XOR this.
    localparam int RESET_CYCLES  = 8;
    localparam int ORDER_CYCLES  = 160;
    localparam int STALL_CYCLES  = 60;
    localparam int RESUME_CYCLES = 80;
    localparam int NEW_CYCLES    = 92;
    // Ten times the stimulus length leaves room for every memory wait.
    localparam int WATCHDOG_CYCLES =
        10 * (RESET_CYCLES + ORDER_CYCLES + STALL_CYCLES + RESUME_CYCLES + NEW_CYCLES);
    localparam int T_RESET = 0;
    localparam int T_ORDER = 1;
    localparam int T_MEM   = 2;
    localparam int T_FULL  = 3;
    localparam int T_HIT   = 4;
    localparam int T_NEW   = 5;

    logic              clk;
    logic              reset_i;
    fetch_pkg::addr_t  bmem_addr_o;
    logic              bmem_read_o;
    logic              bmem_ready_i;
    fetch_pkg::addr_t  bmem_raddr_i;
    fetch_pkg::beat_t  bmem_rdata_i;
    logic              bmem_rvalid_i;
    logic              redirect_i;
    fetch_pkg::addr_t  redirect_pc_i;
    fetch_pkg::instr_t instr_o;
    logic              instr_valid_o;
    logic              instr_deq_i;

    logic [31:0] mem_rnd = 32'd3;
    logic [31:0] deq_rnd = 32'd3;
    logic [31:0] exp_pc;                    // Pc the next dequeued instruction must carry.
    logic        burst_owed = 1'b0;
    logic        req_seen = 1'b0;
    logic        hit_phase = 1'b0;
    logic        stall = 1'b0;
    logic        stall_end = 1'b0;
    logic        new_line_seen = 1'b0;
    logic        new_line_check = 1'b0;
    int          cur_test = T_RESET;
    int          cycle_cnt = 0;
    int          failed = 0;
    int          errs [6] = '{default: 0};
    string       names [6] = '{"reset", "order", "memory", "backpressure", "redirect-hit",
                               "redirect-new"};

    cpu dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Two instructions per beat with the lower address in the low half.
    function automatic logic [63:0] beat_data(input logic [31:0] addr);
        return {(addr + 32'd4) ^ MAGIC, addr ^ MAGIC};
    endfunction

    task automatic count_error(input int t, input string what);
        errs[t]++;
        $display("%s: %s", names[t], what);
    endtask

    task automatic value_error(input int t, input logic [31:0] expected, input logic [31:0] actual);
        errs[t]++;
        $display("ERROR %s: expected %h, actual %h", names[t], expected, actual);
    endtask

    task automatic report_test(input int t);
        if (errs[t] == 0) begin
            $display("%-13s ok", names[t]);
        end else begin
            failed++;
            $display("%-13s failed with %0d errors", names[t], errs[t]);
        end
    endtask

    task automatic run_dequeue(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            deq_rnd     = lcg_next(deq_rnd);
            instr_deq_i = deq_rnd[20];
        end
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        @(negedge clk);
        instr_deq_i   = 1'b0;
        redirect_i    = 1'b1;
        redirect_pc_i = pc;
        @(negedge clk);
        redirect_i    = 1'b0;
    endtask

    task automatic wait_for_instr();
        instr_deq_i = 1'b0;
        do @(negedge clk); while (!instr_valid_o);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (bmem_read_o) req_seen <= 1'b1;
        if (bmem_read_o && bmem_addr_o == 32'hAAAAB200) new_line_seen <= 1'b1;
        if (reset_i) exp_pc <= RESET_PC;
        else if (redirect_i) exp_pc <= redirect_pc_i;
        else if (instr_deq_i && instr_valid_o) exp_pc <= exp_pc + 32'd4;
    end

    a_reset_quiet: assert property (@(posedge clk)
        (cycle_cnt > 0 && (reset_i || $past(reset_i))) |-> !bmem_read_o && !instr_valid_o)
        else count_error(T_RESET, "bmem_read_o or instr_valid_o high around reset");
    a_first_req: assert property (@(posedge clk) disable iff (reset_i)
        (bmem_read_o && !req_seen) |-> bmem_addr_o == RESET_PC)
        else value_error(T_RESET, RESET_PC, $sampled(bmem_addr_o));
    a_word: assert property (@(posedge clk) disable iff (reset_i)
        (instr_deq_i && instr_valid_o) |-> instr_o.word == (exp_pc ^ MAGIC))
        else value_error(cur_test, $sampled(exp_pc) ^ MAGIC, $sampled(instr_o.word));
    a_pc_step: assert property (@(posedge clk) disable iff (reset_i)
        (instr_deq_i && instr_valid_o) |-> instr_o.pc == exp_pc)
        else value_error(cur_test, $sampled(exp_pc), $sampled(instr_o.pc));
    a_aligned: assert property (@(posedge clk) disable iff (reset_i)
        bmem_read_o |-> bmem_addr_o[4:0] == 5'd0)
        else value_error(T_MEM, 32'd0, {27'd0, $sampled(bmem_addr_o[4:0])});
    a_one_burst: assert property (@(posedge clk) disable iff (reset_i)
        bmem_read_o |-> !burst_owed)
        else count_error(T_MEM, "memory request issued while a burst was still owed");
    a_stays_valid: assert property (@(posedge clk) disable iff (reset_i)
        (stall && instr_valid_o) |=> instr_valid_o)
        else count_error(T_FULL, "instr_valid_o dropped while dequeuing was stopped");
    a_filled: assert property (@(posedge clk) disable iff (reset_i)
        stall_end |-> dut0.queue_full)
        else count_error(T_FULL, "queue never filled while dequeuing was stopped");
    a_cached: assert property (@(posedge clk) disable iff (reset_i)
        (hit_phase && bmem_read_o) |-> bmem_addr_o != RESET_PC)
        else count_error(T_HIT, "cached line of the redirect target was read from memory again");
    a_new_line: assert property (@(posedge clk) disable iff (reset_i)
        new_line_check |-> new_line_seen)
        else count_error(T_NEW, "line of the new redirect target was never requested");

    initial begin : memory_model
        fetch_pkg::addr_t line_addr;
        forever begin
            @(negedge clk);
            if (!reset_i && bmem_read_o) begin
                line_addr = bmem_addr_o;
                mem_rnd   = lcg_next(mem_rnd);
                repeat (mem_rnd[17:16]) @(negedge clk);
                bmem_ready_i = 1'b1;
                @(negedge clk);
                bmem_ready_i = 1'b0;
                burst_owed   = 1'b1;
                for (int i = 0; i < 4; i++) begin
                    mem_rnd = lcg_next(mem_rnd);
                    repeat (mem_rnd[17:16] % 3) @(negedge clk);
                    bmem_raddr_i  = line_addr + 32'(8 * i);
                    bmem_rdata_i  = beat_data(bmem_raddr_i);
                    bmem_rvalid_i = 1'b1;
                    @(negedge clk);
                    bmem_rvalid_i = 1'b0;
                end
                burst_owed = 1'b0;
            end
        end
    end

    initial begin : stimulus
        reset_i       = 1'b1;
        bmem_ready_i  = 1'b0;
        bmem_rvalid_i = 1'b0;
        bmem_raddr_i  = '0;
        bmem_rdata_i  = '0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        instr_deq_i   = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;
        wait_for_instr();
        report_test(T_RESET);
        cur_test = T_ORDER;
        run_dequeue(ORDER_CYCLES);
        report_test(T_ORDER);
        cur_test = T_HIT;
        redirect_to(32'hAAAAA010);
        hit_phase = 1'b1;
        wait_for_instr();
        instr_deq_i = 1'b1;                 // Pop the redirect target alone.
        @(negedge clk);
        instr_deq_i = 1'b0;
        cur_test    = T_FULL;
        stall       = 1'b1;
        repeat (STALL_CYCLES) @(negedge clk);
        stall     = 1'b0;
        stall_end = 1'b1;
        @(negedge clk);
        stall_end = 1'b0;
        run_dequeue(RESUME_CYCLES);
        hit_phase = 1'b0;
        report_test(T_FULL);
        report_test(T_HIT);
        cur_test = T_NEW;
        redirect_to(32'hAAAAB204);
        wait_for_instr();
        run_dequeue(NEW_CYCLES);
        new_line_check = 1'b1;
        @(negedge clk);
        new_line_check = 1'b0;
        report_test(T_NEW);
        report_test(T_MEM);
        $display("%0d tests run, %0d failed", 6, failed);
        if (failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule : cpu_tb

// File: vlog.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/deserializer.sv
hdl/cache.sv
hdl/queue.sv
hdl/fetch.sv
hdl/cpu.sv
tb/cpu_tb.sv
